// File: design/oc_pkg.sv
package oc_pkg;

    localparam int N_WARPS     = 4;
    localparam int N_ARCH_REGS = 8;
    localparam int N_BANKS     = 4;   // fixed because the mapping below relies on it
    localparam int N_ROWS      = 8;
    localparam int N_COLL      = 4;
    localparam int LANE_W      = 32;

    typedef logic [$clog2(N_WARPS)-1:0]     warp_id_t;
    typedef logic [$clog2(N_ARCH_REGS)-1:0] reg_id_t;
    typedef logic [$clog2(N_BANKS)-1:0]     bank_id_t;
    typedef logic [$clog2(N_ROWS)-1:0]      row_id_t;
    typedef logic [$clog2(N_COLL)-1:0]      coll_id_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_MUL = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        COLLECT = 2'd1,
        READY   = 2'd2
    } coll_state_e;

    typedef struct packed {
        warp_id_t    warp;
        reg_id_t     src1;
        logic        src1_valid;
        reg_id_t     src2;
        logic        src2_valid;
        reg_id_t     dst;
        logic [15:0] imm;
        logic        imm_valid;
        alu_op_e     alu_op;
        logic        reg_write;
    } oc_instr_t;

    function automatic bank_id_t bank_of(input warp_id_t w, input reg_id_t r);
        logic [2:0] sum;
        sum = r + w;
        return sum[1:0];   // (reg + warp) mod 4
    endfunction

    function automatic row_id_t row_of(input warp_id_t w, input reg_id_t r);
        return {w, r[2]};   // 2*warp + reg/4
    endfunction

endpackage

// File: design/rf_port_if.sv
`timescale 1ns/10ps

interface rf_port_if #(
    parameter int LANES = 4
);

    logic                          wr_en;
    oc_pkg::row_id_t               wr_row;
    logic [LANES-1:0]              wr_mask;
    logic [LANES*oc_pkg::LANE_W-1:0] wr_data;
    logic                          rd_en;
    oc_pkg::row_id_t               rd_row;
    logic [LANES*oc_pkg::LANE_W-1:0] rd_data;   // one cycle after rd_en

    modport arbiter (
        output wr_en, wr_row, wr_mask, wr_data,
        output rd_en, rd_row,
        input  rd_data
    );

    modport bank (
        input  wr_en, wr_row, wr_mask, wr_data,
        input  rd_en, rd_row,
        output rd_data
    );

endinterface

// File: design/opnd_if.sv
`timescale 1ns/10ps

interface opnd_if #(
    parameter int LANES = 4
);

    logic [1:0]                      req;   // bit 0 src1, bit 1 src2
    oc_pkg::bank_id_t                req_bank [2];
    oc_pkg::row_id_t                 req_row [2];
    logic [1:0]                      grant;
    logic [1:0]                      fill;  // one cycle after grant
    logic [LANES*oc_pkg::LANE_W-1:0] fill_data [2];

    modport collector (
        output req, req_bank, req_row,
        input  grant, fill, fill_data
    );

    modport arbiter (
        input  req, req_bank, req_row,
        output grant, fill, fill_data
    );

endinterface

// File: design/reg_bank.sv
`timescale 1ns/10ps

module reg_bank #(
    parameter int LANES = 4
) (
    input logic clk,
    rf_port_if.bank rf
);

    localparam int W = oc_pkg::LANE_W;

    logic [LANES*W-1:0] mem [oc_pkg::N_ROWS];

    always_ff @(posedge clk) begin
        if (rf.wr_en) begin
            for (int l = 0; l < LANES; l++) begin
                if (rf.wr_mask[l]) begin
                    mem[rf.wr_row][l*W +: W] <= rf.wr_data[l*W +: W];
                end
            end
        end
        if (rf.rd_en) begin
            rf.rd_data <= mem[rf.rd_row];
        end
    end

endmodule

// File: design/collector_unit.sv
`timescale 1ns/10ps

module collector_unit #(
    parameter int LANES = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  oc_pkg::oc_instr_t               instr,
    input  logic                            unload,
    output logic                            ready,
    output oc_pkg::oc_instr_t               held_instr,
    output logic [LANES*oc_pkg::LANE_W-1:0] opa,
    output logic [LANES*oc_pkg::LANE_W-1:0] opb,
    opnd_if.collector                       opnd
);

    localparam int DW = LANES * oc_pkg::LANE_W;

    oc_pkg::coll_state_e      state;
    logic [1:0]               req_q;
    logic [1:0]               need;
    logic [1:0]               need_next;
    oc_pkg::bank_id_t         bank_q [2];
    oc_pkg::row_id_t          row_q [2];
    logic [DW-1:0]            slot_data [2];
    logic [oc_pkg::LANE_W-1:0] imm_ext;

    assign need_next     = need & ~opnd.fill;
    assign opnd.req      = req_q;
    assign opnd.req_bank = bank_q;
    assign opnd.req_row  = row_q;
    assign ready         = (state == oc_pkg::READY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= oc_pkg::IDLE;
            req_q <= '0;
            need  <= '0;
        end else begin
            case (state)
                oc_pkg::IDLE: begin
                    if (load) begin
                        state <= oc_pkg::COLLECT;
                        req_q <= {instr.src2_valid, instr.src1_valid};
                        need  <= {instr.src2_valid, instr.src1_valid};
                    end
                end
                oc_pkg::COLLECT: begin
                    req_q <= req_q & ~opnd.grant;   // granted slot drops next edge
                    need  <= need_next;
                    if (need_next == 2'b00) begin
                        state <= oc_pkg::READY;
                    end
                end
                oc_pkg::READY: begin
                    if (unload) begin
                        state <= oc_pkg::IDLE;
                    end
                end
                default: state <= oc_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load && state == oc_pkg::IDLE) begin
            held_instr <= instr;
            bank_q[0]  <= oc_pkg::bank_of(instr.warp, instr.src1);
            bank_q[1]  <= oc_pkg::bank_of(instr.warp, instr.src2);
            row_q[0]   <= oc_pkg::row_of(instr.warp, instr.src1);
            row_q[1]   <= oc_pkg::row_of(instr.warp, instr.src2);
        end
        for (int s = 0; s < 2; s++) begin
            if (opnd.fill[s]) begin
                slot_data[s] <= opnd.fill_data[s];
            end
        end
    end

    assign imm_ext = {{(oc_pkg::LANE_W-16){held_instr.imm[15]}}, held_instr.imm};

    assign opa = held_instr.src1_valid ? slot_data[0] : '0;
    assign opb = held_instr.src2_valid ? slot_data[1] :
                 held_instr.imm_valid  ? {LANES{imm_ext}} : '0;   // imm in every lane

endmodule

// File: design/bank_arbiter.sv
`timescale 1ns/10ps

module bank_arbiter #(
    parameter int LANES = 4
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            wb_valid,
    input oc_pkg::warp_id_t                wb_warp,
    input oc_pkg::reg_id_t                 wb_reg,
    input logic [LANES-1:0]                wb_mask,
    input logic [LANES*oc_pkg::LANE_W-1:0] wb_data,
    opnd_if.arbiter                        opnd [oc_pkg::N_COLL],
    rf_port_if.arbiter                     rf [oc_pkg::N_BANKS]
);

    localparam int DW = LANES * oc_pkg::LANE_W;
    localparam int NC = oc_pkg::N_COLL;
    localparam int NB = oc_pkg::N_BANKS;

    logic [1:0]         req [NC];
    oc_pkg::bank_id_t   req_bank [NC][2];
    oc_pkg::row_id_t    req_row [NC][2];
    logic [1:0]         grant [NC];
    logic [1:0]         fill [NC];
    logic [DW-1:0]      fill_data [NC][2];

    oc_pkg::bank_id_t   wb_bank;
    oc_pkg::row_id_t    wb_row;
    logic [NB-1:0]      wr_en;
    logic [NB-1:0]      rd_en;
    oc_pkg::row_id_t    rd_row [NB];
    logic [DW-1:0]      rd_data [NB];
    oc_pkg::coll_id_t   gnt_coll [NB];
    logic               gnt_slot [NB];
    logic [NB-1:0]      fill_v;      // read issued last cycle
    oc_pkg::coll_id_t   fill_coll [NB];
    logic               fill_slot [NB];

    assign wb_bank = oc_pkg::bank_of(wb_warp, wb_reg);
    assign wb_row  = oc_pkg::row_of(wb_warp, wb_reg);

    // writeback first, then lowest collector, src1 before src2
    always_comb begin
        for (int c = 0; c < NC; c++) begin
            grant[c] = '0;
        end
        for (int b = 0; b < NB; b++) begin
            wr_en[b]    = wb_valid && (wb_bank == oc_pkg::bank_id_t'(b));
            rd_en[b]    = 1'b0;
            rd_row[b]   = '0;
            gnt_coll[b] = '0;
            gnt_slot[b] = 1'b0;
            for (int c = 0; c < NC; c++) begin
                for (int s = 0; s < 2; s++) begin
                    if (!wr_en[b] && !rd_en[b] && req[c][s] &&
                        req_bank[c][s] == oc_pkg::bank_id_t'(b)) begin
                        rd_en[b]    = 1'b1;
                        rd_row[b]   = req_row[c][s];
                        gnt_coll[b] = oc_pkg::coll_id_t'(c);
                        gnt_slot[b] = (s == 1);
                        grant[c][s] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_v <= '0;
        end else begin
            fill_v <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        fill_coll <= gnt_coll;
        fill_slot <= gnt_slot;
    end

    // route bank read data back to the requesting slot
    always_comb begin
        for (int c = 0; c < NC; c++) begin
            fill[c]         = '0;
            fill_data[c][0] = '0;
            fill_data[c][1] = '0;
            for (int b = 0; b < NB; b++) begin
                if (fill_v[b] && fill_coll[b] == oc_pkg::coll_id_t'(c)) begin
                    fill[c][fill_slot[b]]      = 1'b1;
                    fill_data[c][fill_slot[b]] = rd_data[b];
                end
            end
        end
    end

    for (genvar c = 0; c < NC; c++) begin : g_opnd
        assign req[c]            = opnd[c].req;
        assign req_bank[c]       = opnd[c].req_bank;
        assign req_row[c]        = opnd[c].req_row;
        assign opnd[c].grant     = grant[c];
        assign opnd[c].fill      = fill[c];
        assign opnd[c].fill_data = fill_data[c];
    end

    for (genvar b = 0; b < NB; b++) begin : g_rf
        assign rf[b].wr_en   = wr_en[b];
        assign rf[b].wr_row  = wb_row;
        assign rf[b].wr_mask = wb_mask;
        assign rf[b].wr_data = wb_data;
        assign rf[b].rd_en   = rd_en[b];
        assign rf[b].rd_row  = rd_row[b];
        assign rd_data[b]    = rf[b].rd_data;
    end

endmodule

// File: design/oc_ctrl.sv
`timescale 1ns/10ps

module oc_ctrl #(
    parameter int LANES = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [oc_pkg::N_COLL-1:0]       ready,
    input  oc_pkg::oc_instr_t               coll_instr [oc_pkg::N_COLL],
    input  logic [LANES*oc_pkg::LANE_W-1:0] coll_opa [oc_pkg::N_COLL],
    input  logic [LANES*oc_pkg::LANE_W-1:0] coll_opb [oc_pkg::N_COLL],
    input  logic                            out_ready,
    output logic                            full,
    output logic [oc_pkg::N_COLL-1:0]       load,
    output logic [oc_pkg::N_COLL-1:0]       unload,
    output logic                            out_valid,
    output oc_pkg::warp_id_t                out_warp,
    output oc_pkg::reg_id_t                 out_dst,
    output oc_pkg::alu_op_e                 out_alu_op,
    output logic                            out_reg_write,
    output logic [LANES*oc_pkg::LANE_W-1:0] out_opa,
    output logic [LANES*oc_pkg::LANE_W-1:0] out_opb
);

    localparam int NC = oc_pkg::N_COLL;
    localparam int CW = $clog2(NC + 1);

    logic [NC-1:0]    busy;
    logic [CW-1:0]    count;          // entries in age queue
    oc_pkg::coll_id_t age_q [NC];     // oldest at 0
    oc_pkg::coll_id_t head;
    oc_pkg::coll_id_t alloc_id;
    oc_pkg::coll_id_t push_idx;
    logic             accept;
    logic             fire;

    assign full      = &busy;
    assign accept    = in_valid && !full;
    assign head      = age_q[0];
    assign out_valid = (count != '0) && ready[head];
    assign fire      = out_valid && out_ready;

    always_comb begin
        alloc_id = '0;
        for (int c = NC - 1; c >= 0; c--) begin
            if (!busy[c]) begin
                alloc_id = oc_pkg::coll_id_t'(c);   // lowest free wins
            end
        end
        load   = '0;
        unload = '0;
        if (accept) begin
            load[alloc_id] = 1'b1;
        end
        if (fire) begin
            unload[head] = 1'b1;
        end
        push_idx = fire ? oc_pkg::coll_id_t'(count - 1'b1) : oc_pkg::coll_id_t'(count);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= '0;
            count <= '0;
        end else begin
            busy  <= (busy | load) & ~unload;
            count <= count + CW'(accept) - CW'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < NC - 1; i++) begin
                age_q[i] <= age_q[i+1];
            end
        end
        if (accept) begin
            age_q[push_idx] <= alloc_id;
        end
    end

    assign out_warp      = coll_instr[head].warp;
    assign out_dst       = coll_instr[head].dst;
    assign out_alu_op    = coll_instr[head].alu_op;
    assign out_reg_write = coll_instr[head].reg_write;
    assign out_opa       = coll_opa[head];
    assign out_opb       = coll_opb[head];

endmodule

// File: design/oc_top.sv
`timescale 1ns/10ps

module oc_top #(
    parameter int LANES = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            in_valid,
    input  oc_pkg::warp_id_t                in_warp,
    input  oc_pkg::reg_id_t                 in_src1,
    input  logic                            in_src1_valid,
    input  oc_pkg::reg_id_t                 in_src2,
    input  logic                            in_src2_valid,
    input  oc_pkg::reg_id_t                 in_dst,
    input  logic [15:0]                     in_imm,
    input  logic                            in_imm_valid,
    input  oc_pkg::alu_op_e                 in_alu_op,
    input  logic                            in_reg_write,
    output logic                            full,

    input  logic                            wb_valid,
    input  oc_pkg::warp_id_t                wb_warp,
    input  oc_pkg::reg_id_t                 wb_reg,
    input  logic [LANES-1:0]                wb_mask,
    input  logic [LANES*oc_pkg::LANE_W-1:0] wb_data,

    output logic                            out_valid,
    output oc_pkg::warp_id_t                out_warp,
    output oc_pkg::reg_id_t                 out_dst,
    output oc_pkg::alu_op_e                 out_alu_op,
    output logic                            out_reg_write,
    output logic [LANES*oc_pkg::LANE_W-1:0] out_opa,
    output logic [LANES*oc_pkg::LANE_W-1:0] out_opb,
    input  logic                            out_ready
);

    localparam int DW = LANES * oc_pkg::LANE_W;

    oc_pkg::oc_instr_t          in_instr;
    logic [oc_pkg::N_COLL-1:0]  load;
    logic [oc_pkg::N_COLL-1:0]  unload;
    logic [oc_pkg::N_COLL-1:0]  ready;
    oc_pkg::oc_instr_t          coll_instr [oc_pkg::N_COLL];
    logic [DW-1:0]              coll_opa [oc_pkg::N_COLL];
    logic [DW-1:0]              coll_opb [oc_pkg::N_COLL];

    rf_port_if #(.LANES(LANES)) rf [oc_pkg::N_BANKS] ();
    opnd_if    #(.LANES(LANES)) opnd [oc_pkg::N_COLL] ();

    assign in_instr = '{
        warp:       in_warp,
        src1:       in_src1,
        src1_valid: in_src1_valid,
        src2:       in_src2,
        src2_valid: in_src2_valid,
        dst:        in_dst,
        imm:        in_imm,
        imm_valid:  in_imm_valid,
        alu_op:     in_alu_op,
        reg_write:  in_reg_write
    };

    oc_ctrl #(.LANES(LANES)) oc_ctrl (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .ready(ready),
        .coll_instr(coll_instr),
        .coll_opa(coll_opa),
        .coll_opb(coll_opb),
        .out_ready(out_ready),
        .full(full),
        .load(load),
        .unload(unload),
        .out_valid(out_valid),
        .out_warp(out_warp),
        .out_dst(out_dst),
        .out_alu_op(out_alu_op),
        .out_reg_write(out_reg_write),
        .out_opa(out_opa),
        .out_opb(out_opb)
    );

    for (genvar c = 0; c < oc_pkg::N_COLL; c++) begin : g_coll
        collector_unit #(.LANES(LANES)) collector_unit (
            .clk(clk),
            .rst(rst),
            .load(load[c]),
            .instr(in_instr),     // load picks the target
            .unload(unload[c]),
            .ready(ready[c]),
            .held_instr(coll_instr[c]),
            .opa(coll_opa[c]),
            .opb(coll_opb[c]),
            .opnd(opnd[c])
        );
    end

    bank_arbiter #(.LANES(LANES)) bank_arbiter (
        .clk(clk),
        .rst(rst),
        .wb_valid(wb_valid),
        .wb_warp(wb_warp),
        .wb_reg(wb_reg),
        .wb_mask(wb_mask),
        .wb_data(wb_data),
        .opnd(opnd),
        .rf(rf)
    );

    for (genvar b = 0; b < oc_pkg::N_BANKS; b++) begin : g_bank
        reg_bank #(.LANES(LANES)) reg_bank (
            .clk(clk),
            .rf(rf[b])
        );
    end

endmodule

// File: testbench/oc_sva.sv
`timescale 1ns/10ps

module oc_sva #(
    parameter int LANES = 4
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            in_valid,
    input logic                            full,
    input logic                            out_valid,
    input logic                            out_ready,
    input oc_pkg::warp_id_t                out_warp,
    input oc_pkg::reg_id_t                 out_dst,
    input oc_pkg::alu_op_e                 out_alu_op,
    input logic                            out_reg_write,
    input logic [LANES*oc_pkg::LANE_W-1:0] out_opa,
    input logic [LANES*oc_pkg::LANE_W-1:0] out_opb
);

    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_warp) && $stable(out_dst) &&
            $stable(out_alu_op) && $stable(out_reg_write) && $stable(out_opa) &&
            $stable(out_opb))
        else $error("execution port changed while stalled");

    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid && !full)
        else $error("out_valid or full high after reset");

    // a held issue is not dropped until a slot frees
    a_full_holds: assert property (@(posedge clk) disable iff (rst)
        in_valid && full && !(out_valid && out_ready) |=> full)
        else $error("full dropped without a dispatch");

endmodule

bind oc_top oc_sva #(.LANES(LANES)) sva (
    .clk(clk), .rst(rst), .in_valid(in_valid), .full(full),
    .out_valid(out_valid), .out_ready(out_ready), .out_warp(out_warp), .out_dst(out_dst),
    .out_alu_op(out_alu_op), .out_reg_write(out_reg_write),
    .out_opa(out_opa), .out_opb(out_opb)
);

// File: testbench/oc_tb.sv
`timescale 1ns/10ps

module oc_tb;

    localparam int LANES   = 4;
    localparam int W       = oc_pkg::LANE_W;
    localparam int DW      = LANES * W;
    localparam int N_INSTR = 96;   // summed over all tests
    localparam int N_WB    = 60;

    typedef struct packed {
        oc_pkg::warp_id_t warp;
        oc_pkg::reg_id_t  dst;
        oc_pkg::alu_op_e  alu_op;
        logic             reg_write;
        logic [DW-1:0]    opa;
        logic [DW-1:0]    opb;
    } result_t;

    logic clk = 1'b0;
    logic rst;
    logic in_valid, in_src1_valid, in_src2_valid, in_imm_valid, in_reg_write;
    oc_pkg::warp_id_t in_warp;
    oc_pkg::reg_id_t  in_src1, in_src2, in_dst;
    logic [15:0]      in_imm;
    oc_pkg::alu_op_e  in_alu_op;
    logic             full;
    logic             wb_valid;
    oc_pkg::warp_id_t wb_warp;
    oc_pkg::reg_id_t  wb_reg;
    logic [LANES-1:0] wb_mask;
    logic [DW-1:0]    wb_data;
    logic             out_valid, out_reg_write, out_ready;
    oc_pkg::warp_id_t out_warp;
    oc_pkg::reg_id_t  out_dst;
    oc_pkg::alu_op_e  out_alu_op;
    logic [DW-1:0]    out_opa, out_opb;

    logic [31:0]   rng = 32'h4cc;
    logic [DW-1:0] model [oc_pkg::N_WARPS][oc_pkg::N_ARCH_REGS];
    result_t       exp_q [$];
    int            n_checks = 0;
    int            n_errors = 0;
    int            n_issued = 0;
    int            ready_mode = 1;   // 0 low, 1 high, 2 random

    oc_top #(.LANES(LANES)) UUT (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_warp(in_warp), .in_src1(in_src1),
        .in_src1_valid(in_src1_valid), .in_src2(in_src2), .in_src2_valid(in_src2_valid),
        .in_dst(in_dst), .in_imm(in_imm), .in_imm_valid(in_imm_valid),
        .in_alu_op(in_alu_op), .in_reg_write(in_reg_write), .full(full),
        .wb_valid(wb_valid), .wb_warp(wb_warp), .wb_reg(wb_reg),
        .wb_mask(wb_mask), .wb_data(wb_data),
        .out_valid(out_valid), .out_warp(out_warp), .out_dst(out_dst),
        .out_alu_op(out_alu_op), .out_reg_write(out_reg_write),
        .out_opa(out_opa), .out_opb(out_opb), .out_ready(out_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [DW-1:0] rand_data();
        logic [DW-1:0] d;
        for (int l = 0; l < LANES; l++) begin
            d[l*W +: W] = xorshift32();
        end
        return d;
    endfunction

    function automatic oc_pkg::oc_instr_t rand_instr();
        logic [31:0] r;
        logic [31:0] r2;
        oc_pkg::oc_instr_t i;
        r  = xorshift32();
        r2 = xorshift32();
        i.warp       = r[1:0];
        i.src1       = r[4:2];
        i.src1_valid = r[5];
        i.src2       = r[8:6];
        i.src2_valid = r[9];
        i.dst        = r[12:10];
        i.imm_valid  = r[13];
        i.reg_write  = r[14];
        i.alu_op     = oc_pkg::alu_op_e'({1'b0, r[17:15]});
        i.imm        = r2[15:0];
        return i;
    endfunction

    // expected dispatch from the register model
    function automatic result_t ref_result(input oc_pkg::oc_instr_t i);
        result_t      e;
        logic [W-1:0] imm_ext;
        imm_ext     = {{(W-16){i.imm[15]}}, i.imm};
        e.warp      = i.warp;
        e.dst       = i.dst;
        e.alu_op    = i.alu_op;
        e.reg_write = i.reg_write;
        e.opa       = i.src1_valid ? model[i.warp][i.src1] : '0;
        if (i.src2_valid) begin
            e.opb = model[i.warp][i.src2];
        end else if (i.imm_valid) begin
            e.opb = {LANES{imm_ext}};
        end else begin
            e.opb = '0;
        end
        return e;
    endfunction

    task automatic check_data(input string what, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input oc_pkg::alu_op_e got, input oc_pkg::alu_op_e exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0t ns: alu_op is %s, expected %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic check_meta(input oc_pkg::warp_id_t got_warp, input oc_pkg::warp_id_t exp_warp,
                              input oc_pkg::reg_id_t got_dst, input oc_pkg::reg_id_t exp_dst,
                              input logic got_rw, input logic exp_rw);
        n_checks++;
        if (got_warp !== exp_warp || got_dst !== exp_dst || got_rw !== exp_rw) begin
            n_errors++;
            $display("[ERROR] %0t ns: warp/dst/reg_write is %0d/%0d/%b, expected %0d/%0d/%b",
                     $time, got_warp, got_dst, got_rw, exp_warp, exp_dst, exp_rw);
        end
    endtask

    // handshake completes on the next rising edge
    always @(negedge clk) begin : compare
        result_t e;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("dispatch at %0t ns with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                check_meta(out_warp, e.warp, out_dst, e.dst, out_reg_write, e.reg_write);
                check_op(out_alu_op, e.alu_op);
                check_data("opa", out_opa, e.opa);
                check_data("opb", out_opb, e.opb);
            end
        end
    end

    always @(posedge clk) begin : drive_ready
        logic [31:0] r;
        r = xorshift32();   // drawn on the edge itself
        #2;
        out_ready = (ready_mode == 2) ? r[7] : (ready_mode == 1);
    end

    task automatic issue(input oc_pkg::oc_instr_t i);
        in_valid      = 1'b1;
        in_warp       = i.warp;
        in_src1       = i.src1;
        in_src1_valid = i.src1_valid;
        in_src2       = i.src2;
        in_src2_valid = i.src2_valid;
        in_dst        = i.dst;
        in_imm        = i.imm;
        in_imm_valid  = i.imm_valid;
        in_alu_op     = i.alu_op;
        in_reg_write  = i.reg_write;
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        exp_q.push_back(ref_result(i));
        n_issued++;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic write_reg(input int w, input int r, input logic [LANES-1:0] mask,
                             input logic [DW-1:0] data);
        wb_valid = 1'b1;
        wb_warp  = oc_pkg::warp_id_t'(w);
        wb_reg   = oc_pkg::reg_id_t'(r);
        wb_mask  = mask;
        wb_data  = data;
        for (int l = 0; l < LANES; l++) begin
            if (mask[l]) begin
                model[w][r][l*W +: W] = data[l*W +: W];
            end
        end
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic read_all(input logic pair);
        oc_pkg::oc_instr_t i;
        for (int k = 0; k < 32; k++) begin
            i            = rand_instr();
            i.warp       = oc_pkg::warp_id_t'(k / 8);
            i.src1       = oc_pkg::reg_id_t'(k % 8);
            i.src2       = pair ? oc_pkg::reg_id_t'(7 - k % 8) : i.src1;
            i.src1_valid = 1'b1;
            i.src2_valid = 1'b1;
            issue(i);
        end
        drain();
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
    endtask

    task automatic run_conflict();
        oc_pkg::oc_instr_t ins [8];
        int                w2;
        for (int k = 0; k < 8; k++) begin
            ins[k]            = rand_instr();
            ins[k].warp       = 2'd1;
            ins[k].src1       = oc_pkg::reg_id_t'(k);         // r and r+4 share a bank
            ins[k].src2       = oc_pkg::reg_id_t'(k + 4);
            ins[k].src1_valid = 1'b1;
            ins[k].src2_valid = 1'b1;
        end
        fork
            for (int k = 0; k < 8; k++) begin
                issue(ins[k]);
            end
            for (int k = 0; k < 12; k++) begin
                w2 = (k % 3 == 0) ? 0 : k % 3 + 1;
                write_reg(w2, ((k % 4 + 1 - w2) & 3) + 4 * (k & 1), LANES'(xorshift32()),
                          rand_data());
            end
        join
        drain();
    endtask

    task automatic run_backpressure();
        int base;
        base       = n_issued;
        ready_mode = 0;
        @(posedge clk);
        #2;
        fork
            for (int k = 0; k < 6; k++) begin
                issue(rand_instr());
            end
            begin
                @(negedge clk);
                while (!full) begin
                    @(negedge clk);
                end
                if (n_issued - base != 4) begin
                    n_errors++;
                    $display("[ERROR] %0t ns: %0d accepted when full rose, expected 4",
                             $time, n_issued - base);
                end
                repeat (5) @(negedge clk);
                if (n_issued - base != 4 || !full) begin
                    n_errors++;
                    $display("[ERROR] %0t ns: issue not held while stalled", $time);
                end
                ready_mode = 2;
            end
        join
        drain();
        ready_mode = 1;
    endtask

    initial begin
        oc_pkg::oc_instr_t i;
        int c0;
        int e0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_warp       = '0;
        in_src1       = '0;
        in_src1_valid = 1'b0;
        in_src2       = '0;
        in_src2_valid = 1'b0;
        in_dst        = '0;
        in_imm        = '0;
        in_imm_valid  = 1'b0;
        in_alu_op     = oc_pkg::ALU_ADD;
        in_reg_write  = 1'b0;
        wb_valid      = 1'b0;
        wb_warp       = '0;
        wb_reg        = '0;
        wb_mask       = '0;
        wb_data       = '0;
        out_ready     = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 32; k++) begin
            write_reg(k / 8, k % 8, '1, rand_data());
        end
        drain();
        read_all(1'b1);
        report_test("writeback and read-back", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        for (int k = 0; k < 16; k++) begin
            write_reg(xorshift32() % 4, xorshift32() % 8, LANES'(xorshift32()), rand_data());
        end
        read_all(1'b0);
        report_test("masked writeback", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        i            = rand_instr();
        i.src1_valid = 1'b1;
        i.src2_valid = 1'b0;
        i.imm_valid  = 1'b1;
        i.imm        = 16'h8001;
        issue(i);
        i.imm = 16'hfffe;
        issue(i);
        i.imm = 16'h1234;
        issue(i);
        i.src1_valid = 1'b0;
        i.imm_valid  = 1'b0;
        issue(i);
        i.src2_valid = 1'b1;
        issue(i);
        i.src2_valid = 1'b0;
        i.imm_valid  = 1'b1;
        i.imm        = 16'hff80;
        issue(i);
        drain();
        report_test("immediate and absent operands", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        ready_mode = 2;
        for (int k = 0; k < 12; k++) begin
            issue(rand_instr());
        end
        drain();
        ready_mode = 1;
        report_test("order and metadata", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        run_backpressure();
        report_test("back-pressure and full", c0, e0);

        c0 = n_checks;
        e0 = n_errors;
        run_conflict();
        report_test("bank conflicts", c0, e0);

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #((N_INSTR + N_WB) * 50 * 40);
        $display("run timed out after %0d ns with %0d results outstanding", $time, exp_q.size());
        $display("test failed");
        $finish;
    end

endmodule

// File: sources.f
design/oc_pkg.sv
design/rf_port_if.sv
design/opnd_if.sv
design/reg_bank.sv
design/collector_unit.sv
design/bank_arbiter.sv
design/oc_ctrl.sv
design/oc_top.sv
testbench/oc_sva.sv
testbench/oc_tb.sv
